/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cv_glue
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/cart_mapper.sv */
`timescale 1ns/10ps

module cart_mapper (
        input  logic                    clk_sys,
        input  logic                    rst_i,
        dl_if.sink                      dl,
        input  cv_mem_pkg::ram_addr_t   cpu_ram_addr_i,
        output cv_mem_pkg::ram_addr_t   ram_addr_o,
        output cv_mem_pkg::cart_pages_t cart_pages_o,
        output logic                    sg1000_o,
        output logic                    extram_o,
        output logic                    console_reset_o
);

        logic in_window;
        logic window_start;

        assign in_window    = (dl.addr[24:13] == cv_mem_pkg::EXTRAM_WINDOW);
        assign window_start = (dl.addr[12:0] == 13'd0);

        // ==============================
        // Download tracking
        // ==============================

        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        cart_pages_o <= '0;
                        sg1000_o     <= 1'b0;
                        extram_o     <= 1'b0;
                end else if (dl.wr) begin
                        cart_pages_o <= dl.addr[19:14];

                        // New image starts
                        if (dl.addr == '0) begin
                                extram_o <= 1'b0;
                                sg1000_o <= (dl.index[4:0] == cv_mem_pkg::SG1000_INDEX);
                        end

                        // Window must be FFh from its first byte on
                        if (in_window && sg1000_o) begin
                                extram_o <= (window_start || extram_o) && (&dl.data);
                        end
                end
        end

        // ==============================
        // RAM address and console reset
        // ==============================

        always_comb begin
                ram_addr_o = cpu_ram_addr_i;
                if (!extram_o) begin
                        ram_addr_o[$bits(cv_mem_pkg::ram_addr_t)-1:cv_mem_pkg::RAM_SMALL_BITS] = '0;
                end
        end

        // Console stays in reset for the whole download
        assign console_reset_o = rst_i | dl.download;

        // Extra RAM is only ever found on an SG-1000 image
        a_extram_sg1000: assert property (
                @(posedge clk_sys) disable iff (rst_i)
                extram_o |-> sg1000_o
        );

endmodule

/* hdl/clk_enable_gen.sv */
`timescale 1ns/10ps

module clk_enable_gen (
        input  logic clk_sys,
        input  logic rst_i,
        output logic ce_10m7_o,
        output logic ce_5m3_o
);

        logic [2:0] div_q;

        // Free-running divide by eight, enables taken from the zero states
        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        div_q     <= '0;
                        ce_10m7_o <= 1'b0;
                        ce_5m3_o  <= 1'b0;
                end else begin
                        div_q     <= div_q + 3'd1;
                        ce_10m7_o <= (div_q[1:0] == 2'd0);
                        ce_5m3_o  <= (div_q == 3'd0);
                end
        end

        // The slow enable always lines up with a fast one
        a_ce_aligned: assert property (
                @(posedge clk_sys) disable iff (rst_i)
                ce_5m3_o |-> ce_10m7_o
        );

endmodule

/* hdl/controller_ports.sv */
`timescale 1ns/10ps

// Select lines from the console, code and trigger back from one pad
interface ctrl_port_if;

        logic                   sel_keypad_n;
        logic                   sel_joy_n;
        cv_ctrl_pkg::key_code_t code;
        logic                   trigger_n;

        modport host (output sel_keypad_n, sel_joy_n, input code, trigger_n);
        modport pad  (input sel_keypad_n, sel_joy_n, output code, trigger_n);

endinterface

module controller_ports (
        input  cv_ctrl_pkg::joy_word_t                joy0_i,
        input  cv_ctrl_pkg::joy_word_t                joy1_i,
        input  logic                                  swap_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   sel_keypad_n_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   sel_joy_n_i,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   ctrl_p1_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   ctrl_p2_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   ctrl_p3_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   ctrl_p4_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0]   ctrl_p6_o
);

        cv_ctrl_pkg::joy_word_t joy_pad [cv_ctrl_pkg::NUM_PLAYERS];

        // Player swap
        assign joy_pad[0] = swap_i ? joy1_i : joy0_i;
        assign joy_pad[1] = swap_i ? joy0_i : joy1_i;

        for (genvar p = 0; p < cv_ctrl_pkg::NUM_PLAYERS; p++) begin : g_player
                ctrl_port_if port ();

                assign port.sel_keypad_n = sel_keypad_n_i[p];
                assign port.sel_joy_n    = sel_joy_n_i[p];

                keypad_encoder keypad_encoder_i (
                        .joy_i (joy_pad[p]),
                        .port  (port.pad)
                );

                // Code bit 3 goes to pin 1, bit 0 to pin 4
                assign {ctrl_p1_o[p], ctrl_p2_o[p], ctrl_p3_o[p], ctrl_p4_o[p]} = port.code;
                assign ctrl_p6_o[p] = port.trigger_n;
        end

endmodule

/* hdl/cv_ctrl_pkg.sv */
package cv_ctrl_pkg;

        // ==============================
        // Gamepad word
        // ==============================

        typedef logic [31:0] joy_word_t;

        localparam int JOY_RIGHT    = 0;
        localparam int JOY_LEFT     = 1;
        localparam int JOY_DOWN     = 2;
        localparam int JOY_UP       = 3;
        localparam int JOY_FIRE_1   = 4;
        localparam int JOY_FIRE_2   = 5;
        localparam int JOY_ASTERISK = 6;
        localparam int JOY_NUMBER   = 7;
        // Keys 0 to 9 sit on consecutive bits from here
        localparam int JOY_KEY_0    = 8;
        localparam int JOY_PURPLE   = 18;
        localparam int JOY_BLUE     = 19;

        // ==============================
        // Controller codes
        // ==============================

        typedef logic [3:0] key_code_t;

        localparam key_code_t KEY_0        = 4'b0011;
        localparam key_code_t KEY_1        = 4'b1110;
        localparam key_code_t KEY_2        = 4'b1101;
        localparam key_code_t KEY_3        = 4'b0110;
        localparam key_code_t KEY_4        = 4'b0001;
        localparam key_code_t KEY_5        = 4'b1001;
        localparam key_code_t KEY_6        = 4'b0111;
        localparam key_code_t KEY_7        = 4'b1100;
        localparam key_code_t KEY_8        = 4'b1000;
        localparam key_code_t KEY_9        = 4'b1011;
        localparam key_code_t KEY_ASTERISK = 4'b1010;
        localparam key_code_t KEY_NUMBER   = 4'b0101;
        localparam key_code_t KEY_PURPLE   = 4'b0100;
        localparam key_code_t KEY_BLUE     = 4'b0010;
        localparam key_code_t KEY_NONE     = 4'b1111;

        localparam int NUM_PLAYERS = 2;

endpackage

/* hdl/cv_glue_top.sv */
`timescale 1ns/10ps

module cv_glue_top (
        input  logic                                clk_sys,
        input  logic                                rst_i,
        // Download stream
        input  logic                                dl_download_i,
        input  cv_mem_pkg::dl_index_t               dl_index_i,
        input  logic                                dl_wr_i,
        input  cv_mem_pkg::dl_addr_t                dl_addr_i,
        input  cv_mem_pkg::byte_t                   dl_data_i,
        // CPU RAM
        input  cv_mem_pkg::ram_addr_t               cpu_ram_addr_i,
        output cv_mem_pkg::ram_addr_t               ram_addr_o,
        // Controllers
        input  cv_ctrl_pkg::joy_word_t              joy0_i,
        input  cv_ctrl_pkg::joy_word_t              joy1_i,
        input  logic                                swap_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] sel_keypad_n_i,
        input  logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] sel_joy_n_i,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] ctrl_p1_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] ctrl_p2_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] ctrl_p3_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] ctrl_p4_o,
        output logic [cv_ctrl_pkg::NUM_PLAYERS-1:0] ctrl_p6_o,
        // Clock enables and console status
        output logic                                ce_10m7_o,
        output logic                                ce_5m3_o,
        output cv_mem_pkg::cart_pages_t             cart_pages_o,
        output logic                                sg1000_o,
        output logic                                extram_o,
        output logic                                console_reset_o
);

        dl_if dl ();

        assign dl.download = dl_download_i;
        assign dl.index    = dl_index_i;
        assign dl.wr       = dl_wr_i;
        assign dl.addr     = dl_addr_i;
        assign dl.data     = dl_data_i;

        clk_enable_gen clk_enable_gen_i (
                .clk_sys   (clk_sys),
                .rst_i     (rst_i),
                .ce_10m7_o (ce_10m7_o),
                .ce_5m3_o  (ce_5m3_o)
        );

        cart_mapper cart_mapper_i (
                .clk_sys         (clk_sys),
                .rst_i           (rst_i),
                .dl              (dl.sink),
                .cpu_ram_addr_i  (cpu_ram_addr_i),
                .ram_addr_o      (ram_addr_o),
                .cart_pages_o    (cart_pages_o),
                .sg1000_o        (sg1000_o),
                .extram_o        (extram_o),
                .console_reset_o (console_reset_o)
        );

        controller_ports controller_ports_i (
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .swap_i         (swap_i),
                .sel_keypad_n_i (sel_keypad_n_i),
                .sel_joy_n_i    (sel_joy_n_i),
                .ctrl_p1_o      (ctrl_p1_o),
                .ctrl_p2_o      (ctrl_p2_o),
                .ctrl_p3_o      (ctrl_p3_o),
                .ctrl_p4_o      (ctrl_p4_o),
                .ctrl_p6_o      (ctrl_p6_o)
        );

endmodule

/* hdl/cv_mem_pkg.sv */
package cv_mem_pkg;

        // ==============================
        // Download stream
        // ==============================

        typedef logic [24:0] dl_addr_t;
        typedef logic [7:0]  dl_index_t;
        typedef logic [7:0]  byte_t;

        // Page count comes from download address bits 19 to 14
        typedef logic [5:0]  cart_pages_t;

        // Low five index bits of an SG-1000 image
        localparam logic [4:0] SG1000_INDEX = 5'd2;

        // Address bits 24 to 13 of the 2000h-3FFFh window
        localparam logic [11:0] EXTRAM_WINDOW = 12'd1;

        // ==============================
        // CPU RAM
        // ==============================

        typedef logic [14:0] ram_addr_t;

        // 8 KB without extra cartridge RAM
        localparam int RAM_SMALL_BITS = 13;

endpackage

/* hdl/dl_if.sv */
`timescale 1ns/10ps

// ROM download stream, one byte per wr cycle and no back-pressure
interface dl_if;

        logic                  download;
        cv_mem_pkg::dl_index_t index;
        logic                  wr;
        cv_mem_pkg::dl_addr_t  addr;
        cv_mem_pkg::byte_t     data;

        modport source (
                output download, index, wr, addr, data
        );

        modport sink (
                input download, index, wr, addr, data
        );

endinterface

/* hdl/keypad_encoder.sv */
`timescale 1ns/10ps

module keypad_encoder (
        input  cv_ctrl_pkg::joy_word_t joy_i,
        ctrl_port_if.pad               port
);

        cv_ctrl_pkg::key_code_t keypad_code;
        cv_ctrl_pkg::key_code_t joy_code;
        logic                   keypad_trig_n;
        logic                   joy_trig_n;

        // ==============================
        // Keypad half
        // ==============================

        // Lowest key number wins, then asterisk, number and the triggers
        always_comb begin
                keypad_code   = cv_ctrl_pkg::KEY_NONE;
                keypad_trig_n = 1'b1;
                if (!port.sel_keypad_n) begin
                        if (joy_i[cv_ctrl_pkg::JOY_KEY_0])
                                keypad_code = cv_ctrl_pkg::KEY_0;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 1])
                                keypad_code = cv_ctrl_pkg::KEY_1;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 2])
                                keypad_code = cv_ctrl_pkg::KEY_2;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 3])
                                keypad_code = cv_ctrl_pkg::KEY_3;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 4])
                                keypad_code = cv_ctrl_pkg::KEY_4;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 5])
                                keypad_code = cv_ctrl_pkg::KEY_5;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 6])
                                keypad_code = cv_ctrl_pkg::KEY_6;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 7])
                                keypad_code = cv_ctrl_pkg::KEY_7;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 8])
                                keypad_code = cv_ctrl_pkg::KEY_8;
                        else if (joy_i[cv_ctrl_pkg::JOY_KEY_0 + 9])
                                keypad_code = cv_ctrl_pkg::KEY_9;
                        else if (joy_i[cv_ctrl_pkg::JOY_ASTERISK])
                                keypad_code = cv_ctrl_pkg::KEY_ASTERISK;
                        else if (joy_i[cv_ctrl_pkg::JOY_NUMBER])
                                keypad_code = cv_ctrl_pkg::KEY_NUMBER;
                        else if (joy_i[cv_ctrl_pkg::JOY_PURPLE])
                                keypad_code = cv_ctrl_pkg::KEY_PURPLE;
                        else if (joy_i[cv_ctrl_pkg::JOY_BLUE])
                                keypad_code = cv_ctrl_pkg::KEY_BLUE;
                        keypad_trig_n = ~joy_i[cv_ctrl_pkg::JOY_FIRE_2];
                end
        end

        // ==============================
        // Joystick half
        // ==============================

        always_comb begin
                joy_code   = '1;
                joy_trig_n = 1'b1;
                if (!port.sel_joy_n) begin
                        joy_code = ~{joy_i[cv_ctrl_pkg::JOY_UP], joy_i[cv_ctrl_pkg::JOY_DOWN],
                                     joy_i[cv_ctrl_pkg::JOY_LEFT], joy_i[cv_ctrl_pkg::JOY_RIGHT]};
                        joy_trig_n = ~joy_i[cv_ctrl_pkg::JOY_FIRE_1];
                end
        end

        // Lines are active low, so both halves share them wired-AND style
        assign port.code      = keypad_code & joy_code;
        assign port.trigger_n = keypad_trig_n & joy_trig_n;

endmodule

/* sim.f */
hdl/cv_mem_pkg.sv
hdl/cv_ctrl_pkg.sv
hdl/dl_if.sv
hdl/clk_enable_gen.sv
hdl/cart_mapper.sv
hdl/controller_ports.sv
hdl/keypad_encoder.sv
hdl/cv_glue_top.sv
testbench/tb_cv_glue.sv

/* testbench/tb_cv_glue.sv */
`timescale 1ns/10ps

module tb_cv_glue;

        // Upper estimate of all tests in cycles, the run may take twice that
        localparam int TEST_CYCLES    = 2500;
        localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
        localparam logic [31:0] SEED  = 32'h8e0c_35dd;

        logic        clk_sys = 1'b0;
        logic        rst_i;
        logic        dl_download_i;
        logic [7:0]  dl_index_i;
        logic        dl_wr_i;
        logic [24:0] dl_addr_i;
        logic [7:0]  dl_data_i;
        logic [14:0] cpu_ram_addr_i;
        logic [14:0] ram_addr_o;
        logic [31:0] joy0_i;
        logic [31:0] joy1_i;
        logic        swap_i;
        logic [1:0]  sel_keypad_n_i;
        logic [1:0]  sel_joy_n_i;
        logic [1:0]  ctrl_p1_o;
        logic [1:0]  ctrl_p2_o;
        logic [1:0]  ctrl_p3_o;
        logic [1:0]  ctrl_p4_o;
        logic [1:0]  ctrl_p6_o;
        logic        ce_10m7_o;
        logic        ce_5m3_o;
        logic [5:0]  cart_pages_o;
        logic        sg1000_o;
        logic        extram_o;
        logic        console_reset_o;

        int          cycle_count    = 0;
        int          error_count    = 0;
        int          released_edges = 0;
        logic [5:0]  exp_pages      = '0;
        logic        exp_sg         = 1'b0;
        logic        exp_ext        = 1'b0;
        logic        window_ff      = 1'b0;

        cv_glue_top cv_glue_top_i (.*);

        initial begin
                forever #10 clk_sys = ~clk_sys;
        end

        // ==============================
        // Reference functions
        // ==============================

        function automatic int key_bit(input int k);
                if (k < 10)
                        return 8 + k;
                case (k)
                        10:      return 6;
                        11:      return 7;
                        12:      return 18;
                        default: return 19;
                endcase
        endfunction

        // Keys 0 to 9, then asterisk, number, purple and blue
        function automatic logic [3:0] key_code(input int k);
                case (k)
                        0:       return 4'b0011;
                        1:       return 4'b1110;
                        2:       return 4'b1101;
                        3:       return 4'b0110;
                        4:       return 4'b0001;
                        5:       return 4'b1001;
                        6:       return 4'b0111;
                        7:       return 4'b1100;
                        8:       return 4'b1000;
                        9:       return 4'b1011;
                        10:      return 4'b1010;
                        11:      return 4'b0101;
                        12:      return 4'b0100;
                        13:      return 4'b0010;
                        default: return 4'b1111;
                endcase
        endfunction

        // Returns {code, trigger_n} of one pad
        function automatic logic [4:0] pad_lines(input logic [31:0] joy, input logic kp_n,
                                                 input logic js_n);
                logic [3:0] kp_code;
                logic [3:0] js_code;
                logic       kp_trig;
                logic       js_trig;

                kp_code = 4'b1111;
                js_code = 4'b1111;
                kp_trig = 1'b1;
                js_trig = 1'b1;
                if (!kp_n) begin
                        // Walk down so the lowest pressed key is the one left
                        for (int k = 13; k >= 0; k--) begin
                                if (joy[key_bit(k)])
                                        kp_code = key_code(k);
                        end
                        kp_trig = ~joy[5];
                end
                if (!js_n) begin
                        js_code = ~{joy[3], joy[2], joy[1], joy[0]};
                        js_trig = ~joy[4];
                end
                return {kp_code & js_code, kp_trig & js_trig};
        endfunction

        function automatic logic [31:0] rand_joy();
                return ($urandom & $urandom & $urandom) << $urandom_range(12, 0);
        endfunction

        task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                                   input string what);
                if (actual !== expected) begin
                        error_count++;
                        $display("[FAIL] %0t ns: %s is %0h, expected %0h",
                                 $time, what, actual, expected);
                        $display("Finished with errors");
                        $fatal(1, "Stopped at the first mismatch");
                end
        endtask

        // ==============================
        // Comparison and model update
        // ==============================

        always @(negedge clk_sys) begin
                logic [31:0] pad;
                logic [4:0]  lines;
                logic [9:0]  exp_ports;
                logic [1:0]  exp_ce;

                exp_ce[1] = (released_edges > 0) && ((released_edges - 1) % 4 == 0);
                exp_ce[0] = (released_edges > 0) && ((released_edges - 1) % 8 == 0);
                check_equal(32'({ce_10m7_o, ce_5m3_o}), 32'(exp_ce), "Clock enables");
                check_equal(32'({cart_pages_o, sg1000_o, extram_o}),
                            32'({exp_pages, exp_sg, exp_ext}), "Pages and flags");
                check_equal(32'(ram_addr_o),
                            32'(exp_ext ? cpu_ram_addr_i : {2'b00, cpu_ram_addr_i[12:0]}),
                            "RAM address");
                check_equal(32'(console_reset_o), 32'(rst_i | dl_download_i), "Console reset");

                for (int p = 0; p < 2; p++) begin
                        pad   = ((p == 1) != swap_i) ? joy1_i : joy0_i;
                        lines = pad_lines(pad, sel_keypad_n_i[p], sel_joy_n_i[p]);
                        exp_ports[8 + p] = lines[4];
                        exp_ports[6 + p] = lines[3];
                        exp_ports[4 + p] = lines[2];
                        exp_ports[2 + p] = lines[1];
                        exp_ports[p]     = lines[0];
                end
                check_equal(32'({ctrl_p1_o, ctrl_p2_o, ctrl_p3_o, ctrl_p4_o, ctrl_p6_o}),
                            32'(exp_ports), "Controller port lines");

                // Inputs held now are what the next rising edge samples
                if (rst_i) begin
                        released_edges = 0;
                        exp_pages      = '0;
                        exp_sg         = 1'b0;
                        exp_ext        = 1'b0;
                end else begin
                        released_edges++;
                        if (dl_wr_i) begin
                                exp_pages = dl_addr_i[19:14];
                                if (dl_addr_i == 25'd0) begin
                                        exp_sg    = (dl_index_i[4:0] == 5'd2);
                                        exp_ext   = 1'b0;
                                        window_ff = 1'b0;
                                end else if (dl_addr_i[24:13] == 12'd1 && exp_sg) begin
                                        if (dl_addr_i[12:0] == 13'd0)
                                                window_ff = 1'b1;
                                        window_ff = window_ff && (dl_data_i == 8'hff);
                                        exp_ext   = window_ff;
                                end
                        end
                end
        end

        // Random CPU address every cycle, plus the run limit
        always @(posedge clk_sys) begin
                cpu_ram_addr_i <= 15'($urandom);
                cycle_count++;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Run timed out after %0d cycles", cycle_count);
                        $display("Finished with errors");
                        $fatal(1, "Timeout");
                end
        end

        // ==============================
        // Stimulus
        // ==============================

        task automatic start_image(input logic [7:0] index);
                @(posedge clk_sys);
                dl_download_i <= 1'b1;
                dl_index_i    <= index;
                dl_wr_i       <= 1'b0;
        endtask

        task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
                // Occasional idle cycle in the stream
                if ($urandom_range(3, 0) == 0) begin
                        @(posedge clk_sys);
                        dl_wr_i <= 1'b0;
                end
                @(posedge clk_sys);
                dl_wr_i   <= 1'b1;
                dl_addr_i <= addr;
                dl_data_i <= data;
        endtask

        task automatic end_image();
                @(posedge clk_sys);
                dl_wr_i       <= 1'b0;
                dl_download_i <= 1'b0;
                @(negedge clk_sys);
        endtask

        // Sparse SG-1000 image, bad_slot below zero keeps the window all FFh
        task automatic send_sg_image(input int bad_slot);
                start_image(8'h42);
                write_byte(25'd0, 8'h3e);
                for (int j = 0; j < 32; j++) begin
                        write_byte(25'(32'h2000 + j * 256), (j == bad_slot) ? 8'h7f : 8'hff);
                end
                write_byte(25'h4000, 8'($urandom));
                end_image();
        endtask

        task automatic drive_pads(input logic [1:0] kp_n, input logic [1:0] js_n,
                                  input logic swap, input int cycles);
                repeat (cycles) begin
                        @(posedge clk_sys);
                        joy0_i         <= rand_joy();
                        joy1_i         <= rand_joy();
                        sel_keypad_n_i <= kp_n;
                        sel_joy_n_i    <= js_n;
                        swap_i         <= swap;
                end
        endtask

        initial begin
                logic [24:0] addr;

                void'($urandom(SEED));
                rst_i          = 1'b1;
                dl_download_i  = 1'b0;
                dl_index_i     = '0;
                dl_wr_i        = 1'b0;
                dl_addr_i      = '0;
                dl_data_i      = '0;
                cpu_ram_addr_i = '0;
                joy0_i         = '0;
                joy1_i         = '0;
                swap_i         = 1'b0;
                sel_keypad_n_i = 2'b11;
                sel_joy_n_i    = 2'b11;
                repeat (8) @(posedge clk_sys);
                rst_i <= 1'b0;

                // Enables free-run for a while
                repeat (40) @(posedge clk_sys);

                // Plain cartridge over several pages
                start_image(8'h00);
                write_byte(25'd0, 8'($urandom));
                for (int i = 1; i <= 64; i++) begin
                        addr = 25'(i * 32'h2000);
                        write_byte(addr, addr[24:13] == 12'd1 ? 8'hff : 8'($urandom));
                end
                end_image();
                check_equal(32'({sg1000_o, extram_o}), 32'd0, "Flags after cartridge");

                send_sg_image(-1);
                check_equal(32'({sg1000_o, extram_o}), 32'd3, "Flags after full window");
                check_equal(32'(ram_addr_o), 32'(cpu_ram_addr_i), "RAM address with extra RAM");

                send_sg_image(17);
                check_equal(32'({sg1000_o, extram_o}), 32'd2, "Flags after broken window");
                check_equal(32'(ram_addr_o[14:13]), 32'd0, "RAM address upper bits");

                // Keypad, joystick, both and mixed per player
                drive_pads(2'b00, 2'b11, 1'b0, 400);
                drive_pads(2'b00, 2'b11, 1'b1, 400);
                drive_pads(2'b11, 2'b00, 1'b0, 400);
                drive_pads(2'b00, 2'b00, 1'b1, 400);
                drive_pads(2'b01, 2'b10, 1'b0, 200);
                drive_pads(2'b11, 2'b11, 1'b0, 20);
                @(negedge clk_sys);
                check_equal(32'({ctrl_p1_o, ctrl_p2_o, ctrl_p3_o, ctrl_p4_o, ctrl_p6_o}),
                            32'h3ff, "Port lines with no mode selected");

                if (error_count == 0) begin
                        $display("Finished with no errors");
                        $finish;
                end else begin
                        $display("Finished with errors");
                        $fatal(1, "Checks failed");
                end
        end

endmodule
